// File: hw/dcache_pkg.sv
// ==============================
// Shared types for the L1 data cache
// Address fields, access sizes, request structs
// and the uncached address windows
// ==============================
package dcache_pkg;

    // ==============================
    // Address layout
    // ==============================
    // Tag in bits 31..10, index in 9..4, word in 3..2
    localparam int tag_w    = 22;
    localparam int index_w  = 6;
    localparam int offset_w = 4;

    typedef logic [31:0]        addr_t;
    typedef logic [31:0]        word_t;
    typedef logic [127:0]       line_t;
    typedef logic [tag_w-1:0]   tag_t;
    typedef logic [index_w-1:0] index_t;

    // Access size as seen on both ports
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_e;

    // ==============================
    // Request structs
    // ==============================
    // One access from the core
    typedef struct packed {
        addr_t     addr;
        word_t     wdata;
        logic      write;
        acc_size_e size;
    } core_req_t;

    // One beat toward memory
    typedef struct packed {
        addr_t     addr;
        word_t     wdata;
        acc_size_e size;
        logic      write;
        logic      single;
    } mem_req_t;

    // Upper halfword of the two uncached windows
    localparam logic [15:0] uncached_hi_a = 16'h1000;
    localparam logic [15:0] uncached_hi_b = 16'h4000;

    // Words per line, one read beat each
    localparam int refill_beats = 4;

    // Helpers for splitting an address
    function automatic tag_t addr_tag(input addr_t a);
        return a[31 -: tag_w];
    endfunction

    function automatic index_t addr_index(input addr_t a);
        return a[offset_w +: index_w];
    endfunction

endpackage

// File: hw/sram_array.sv
// ==============================
// Synchronous single-port array
// Per-lane write enables, registered read
// ==============================
`timescale 1ns/1ps

module sram_array import dcache_pkg::*; #(
    parameter type entry_t = line_t,
    parameter int  lanes   = 16,
    parameter int  depth   = 64
) (
    input  logic             clk,
    input  index_t           index,
    input  entry_t           wdata,
    input  logic [lanes-1:0] wmask,
    input  logic             read_en,
    output entry_t           rdata
);

    localparam int width  = $bits(entry_t);
    localparam int lane_w = width / lanes;

    logic [width-1:0] mem [depth];
    logic [width-1:0] wbits;

    assign wbits = wdata;

    // Each enabled lane is written at the edge
    always_ff @(posedge clk) begin
        for (int l = 0; l < lanes; l++) begin
            if (wmask[l]) begin
                mem[index][l*lane_w +: lane_w] <= wbits[l*lane_w +: lane_w];
            end
        end
    end

    // Output holds its last value when not read
    always_ff @(posedge clk) begin
        if (read_en) begin
            rdata <= entry_t'(mem[index]);
        end
    end

endmodule

// File: hw/store_align.sv
// ==============================
// Store data alignment
// Replicated store data and byte mask
// ==============================
`timescale 1ns/1ps

module store_align import dcache_pkg::*; (
    input  core_req_t   cmd,
    output line_t       lane_data,
    output logic [15:0] lane_mask
);

    logic [3:0] byte_sel;

    assign byte_sel = cmd.addr[offset_w-1:0];

    // ==============================
    // Data replication
    // ==============================
    always_comb begin
        case (cmd.size)
            size_byte: lane_data = {16{cmd.wdata[7:0]}};
            size_half: lane_data = {8{cmd.wdata[15:0]}};
            default:   lane_data = {4{cmd.wdata}};
        endcase
    end

    // ==============================
    // Byte lane mask
    // ==============================
    // Halves and words are forced to their natural alignment
    always_comb begin
        case (cmd.size)
            size_byte: begin
                lane_mask = 16'h0001 << byte_sel;
            end
            size_half: begin
                lane_mask = 16'h0003 << {byte_sel[3:1], 1'b0};
            end
            default: begin
                lane_mask = 16'h000f << {byte_sel[3:2], 2'b00};
            end
        endcase
    end

endmodule

// File: hw/dcache_ctrl.sv
// ==============================
// Data cache controller
// Hit check, valid bits, refill sequencing,
// write-through and uncached bypass
// ==============================
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int num_lines = 64
) (
    input  logic        clk,
    input  logic        rst,
    // Core side
    input  logic        core_req,
    input  core_req_t   core_cmd,
    output word_t       core_rdata,
    output logic        core_wait,
    // Memory side
    output logic        mem_rreq,
    output logic        mem_wreq,
    output mem_req_t    mem_cmd,
    input  word_t       mem_rdata,
    input  logic        mem_wait,
    // Arrays
    output index_t      arr_index,
    input  tag_t        tag_rdata,
    output tag_t        tag_wdata,
    output logic        tag_we,
    output logic        tag_re,
    input  line_t       line_rdata,
    output line_t       line_wdata,
    output logic [15:0] line_wmask,
    output logic        line_re,
    // Store path
    input  line_t       st_data,
    input  logic [15:0] st_mask
);

    typedef enum logic [2:0] {
        st_idle,
        st_check,
        st_write_hit,
        st_write_miss,
        st_refill,
        st_bypass,
        st_finish
    } state_e;

    state_e state, state_nxt;

    // Captured access
    core_req_t   cmd_q;
    line_t       st_data_q;
    logic [15:0] st_mask_q;
    logic        cacheable_q;

    logic [num_lines-1:0] valid;
    logic [1:0]           beat;
    line_t                line_buf;
    line_t                line_fill;

    logic accept;
    logic hit;
    logic beat_done;
    logic last_beat;
    logic [1:0] word_sel;

    assign accept    = (state == st_idle) && core_req;
    assign beat_done = !mem_wait;
    assign last_beat = (beat == 2'(refill_beats - 1));
    assign word_sel  = cmd_q.addr[3:2];

    // ==============================
    // Command capture
    // ==============================
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q       <= core_cmd;
            st_data_q   <= st_data;
            st_mask_q   <= st_mask;
            cacheable_q <= (core_cmd.addr[31:16] != uncached_hi_a) &&
                           (core_cmd.addr[31:16] != uncached_hi_b);
        end
    end

    // Tag and data are ready in the check cycle
    assign hit = cacheable_q && valid[addr_index(cmd_q.addr)] &&
                 (tag_rdata == addr_tag(cmd_q.addr));

    // ==============================
    // State machine
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (core_req) begin
                    state_nxt = st_check;
                end
            end
            st_check: begin
                if (cmd_q.write) begin
                    state_nxt = hit ? st_write_hit : st_write_miss;
                end else if (!cacheable_q) begin
                    state_nxt = st_bypass;
                end else if (hit) begin
                    state_nxt = st_finish;
                end else begin
                    state_nxt = st_refill;
                end
            end
            st_write_hit, st_write_miss, st_bypass: begin
                if (beat_done) begin
                    state_nxt = st_finish;
                end
            end
            st_refill: begin
                if (beat_done && last_beat) begin
                    state_nxt = st_finish;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // ==============================
    // Refill sequencing
    // ==============================
    // Counter wraps back to zero after the last beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat <= '0;
        end else if (state == st_refill && beat_done) begin
            beat <= beat + 2'd1;
        end
    end

    // Current beat's word dropped into the collected line
    always_comb begin
        line_fill = line_buf;
        line_fill[{beat, 5'b0} +: 32] = mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (state == st_refill && beat_done) begin
            line_buf <= line_fill;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (state == st_refill && beat_done && last_beat) begin
            valid[addr_index(cmd_q.addr)] <= 1'b1;
        end
    end

    // ==============================
    // Array control
    // ==============================
    assign arr_index = (state == st_idle) ? addr_index(core_cmd.addr) : addr_index(cmd_q.addr);
    assign tag_re    = accept;
    assign line_re   = accept;
    assign tag_wdata = addr_tag(cmd_q.addr);
    assign tag_we    = (state == st_refill) && beat_done && last_beat;

    always_comb begin
        line_wdata = st_data_q;
        line_wmask = '0;
        if (state == st_refill) begin
            line_wdata = line_fill;
            if (beat_done && last_beat) begin
                line_wmask = '1;
            end
        end else if (state == st_write_hit && beat_done) begin
            // Merge store bytes once memory took the write
            line_wmask = st_mask_q;
        end
    end

    // ==============================
    // Core side
    // ==============================
    assign core_wait = (state == st_idle)   ? core_req :
                       (state == st_finish) ? 1'b0 : 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            core_rdata <= '0;
        end else begin
            case (state)
                st_check: begin
                    if (!cmd_q.write && hit) begin
                        core_rdata <= line_rdata[{word_sel, 5'b0} +: 32];
                    end
                end
                st_refill: begin
                    if (beat_done && last_beat) begin
                        core_rdata <= line_fill[{word_sel, 5'b0} +: 32];
                    end
                end
                st_bypass: begin
                    if (beat_done) begin
                        core_rdata <= mem_rdata;
                    end
                end
                default: ;
            endcase
        end
    end

    // ==============================
    // Memory side
    // ==============================
    assign mem_wreq = (state == st_write_hit) || (state == st_write_miss);
    assign mem_rreq = (state == st_refill) || (state == st_bypass);

    always_comb begin
        mem_cmd.addr   = cmd_q.addr;
        mem_cmd.wdata  = cmd_q.wdata;
        mem_cmd.size   = cmd_q.write ? cmd_q.size : size_word;
        mem_cmd.write  = cmd_q.write;
        mem_cmd.single = (state == st_bypass);
        if (state == st_refill) begin
            mem_cmd.addr = {cmd_q.addr[31:offset_w], beat, 2'b00};
        end
    end

endmodule

// File: hw/dcache_top.sv
// ==============================
// L1 data cache top level
// Controller, store aligner, tag and data arrays
// ==============================
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int num_lines = 64
) (
    input  logic      clk,
    input  logic      rst,
    // Core side
    input  logic      core_req,
    input  core_req_t core_cmd,
    output word_t     core_rdata,
    output logic      core_wait,
    // Memory side
    output logic      mem_rreq,
    output logic      mem_wreq,
    output mem_req_t  mem_cmd,
    input  word_t     mem_rdata,
    input  logic      mem_wait
);

    index_t      arr_index;
    tag_t        tag_rdata;
    tag_t        tag_wdata;
    logic        tag_we;
    logic        tag_re;
    line_t       line_rdata;
    line_t       line_wdata;
    logic [15:0] line_wmask;
    logic        line_re;
    line_t       st_data;
    logic [15:0] st_mask;

    dcache_ctrl #(
        .num_lines (num_lines)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .core_req   (core_req),
        .core_cmd   (core_cmd),
        .core_rdata (core_rdata),
        .core_wait  (core_wait),
        .mem_rreq   (mem_rreq),
        .mem_wreq   (mem_wreq),
        .mem_cmd    (mem_cmd),
        .mem_rdata  (mem_rdata),
        .mem_wait   (mem_wait),
        .arr_index  (arr_index),
        .tag_rdata  (tag_rdata),
        .tag_wdata  (tag_wdata),
        .tag_we     (tag_we),
        .tag_re     (tag_re),
        .line_rdata (line_rdata),
        .line_wdata (line_wdata),
        .line_wmask (line_wmask),
        .line_re    (line_re),
        .st_data    (st_data),
        .st_mask    (st_mask)
    );

    // Aligner works on the command as presented at acceptance
    store_align u_align (
        .cmd       (core_cmd),
        .lane_data (st_data),
        .lane_mask (st_mask)
    );

    sram_array #(
        .entry_t (tag_t),
        .lanes   (1),
        .depth   (num_lines)
    ) u_tag (
        .clk     (clk),
        .index   (arr_index),
        .wdata   (tag_wdata),
        .wmask   (tag_we),
        .read_en (tag_re),
        .rdata   (tag_rdata)
    );

    sram_array #(
        .entry_t (line_t),
        .lanes   (16),
        .depth   (num_lines)
    ) u_data (
        .clk     (clk),
        .index   (arr_index),
        .wdata   (line_wdata),
        .wmask   (line_wmask),
        .read_en (line_re),
        .rdata   (line_rdata)
    );

endmodule

// File: sim/tb_clock_gen.sv
// ==============================
// Testbench clock and reset
// ==============================
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period = 40
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held over two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: sim/mem_model.sv
// ==============================
// Behavioral memory for the cache
// Random wait states, request log
// ==============================
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; (
    input  logic     clk,
    input  logic     mem_rreq,
    input  logic     mem_wreq,
    input  mem_req_t mem_cmd,
    output word_t    mem_rdata,
    output logic     mem_wait,
    output int       beat_count
);

    // Writable RAM covers the low 16 KB and the rest reads as fill
    word_t    ram [4096];
    mem_req_t log_q [$];
    int       cnt;
    int       delay;

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    always_comb begin
        if (mem_cmd.addr[31:14] == '0) begin
            mem_rdata = ram[mem_cmd.addr[13:2]];
        end else begin
            mem_rdata = fill_word({mem_cmd.addr[31:2], 2'b00});
        end
    end

    // Beat ends once the wait count reaches the drawn delay
    assign mem_wait = (mem_rreq || mem_wreq) && (cnt != delay);

    initial begin : beat_loop
        logic [11:0] widx;
        void'($urandom(78));
        for (int i = 0; i < 4096; i++) begin
            ram[i] = fill_word(32'(i) << 2);
        end
        cnt        = 0;
        delay      = 0;
        beat_count = 0;
        forever begin
            @(posedge clk);
            if ((mem_rreq || mem_wreq) && cnt == delay) begin
                log_q.push_back(mem_cmd);
                // Beats seen so far
                beat_count <= log_q.size();
                cnt        <= 0;
                delay      <= $urandom % 4;
                if (mem_wreq && mem_cmd.addr[31:14] == '0) begin
                    widx = mem_cmd.addr[13:2];
                    case (mem_cmd.size)
                        size_byte: ram[widx][{mem_cmd.addr[1:0], 3'b000} +: 8] <= mem_cmd.wdata[7:0];
                        size_half: ram[widx][{mem_cmd.addr[1], 4'b0000} +: 16] <= mem_cmd.wdata[15:0];
                        default:   ram[widx] <= mem_cmd.wdata;
                    endcase
                end
            end else if (mem_rreq || mem_wreq) begin
                cnt <= cnt + 1;
            end
        end
    end

endmodule

// File: sim/tb_dcache.sv
// ==============================
// Data cache testbench
// Stimulus, reference image, beat and
// result checks, timeout
// ==============================
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int num_accesses = 23;
    localparam int cycle_limit  = 60 * num_accesses;

    logic      clk;
    logic      rst;
    logic      core_req;
    core_req_t core_cmd;
    word_t     core_rdata;
    logic      core_wait;
    logic      mem_rreq;
    logic      mem_wreq;
    mem_req_t  mem_cmd;
    word_t     mem_rdata;
    logic      mem_wait;
    int        beat_count;

    // Reference image of the low 16 KB and a model of the tag state
    word_t    image [4096];
    tag_t     ref_tag [64];
    logic     ref_valid [64];
    mem_req_t exp_q [$];

    int   errors = 0;
    int   checks = 0;
    int   tests  = 0;
    int   cycles = 0;
    logic started;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));
    dcache_top u_dut (.*);
    mem_model u_mem (.*);

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t image_word(input addr_t a);
        if (a[31:14] == '0) begin
            return image[a[13:2]];
        end
        return fill_word({a[31:2], 2'b00});
    endfunction

    // Byte lane rule for sub-word stores
    function automatic word_t merge_store(input word_t old, input core_req_t cmd);
        word_t res;
        res = old;
        case (cmd.size)
            size_byte: res[8 * cmd.addr[1:0] +: 8] = cmd.wdata[7:0];
            size_half: res[16 * cmd.addr[1] +: 16] = cmd.wdata[15:0];
            default:   res = cmd.wdata;
        endcase
        return res;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    // ==============================
    // One core access
    // ==============================
    task automatic run_access(input core_req_t cmd);
        mem_req_t beat;
        int       n_beats;
        int       start_count;
        index_t   idx;
        tag_t     tag;
        logic     cacheable;
        idx         = cmd.addr[9:4];
        tag         = cmd.addr[31:10];
        cacheable   = (cmd.addr[31:16] != uncached_hi_a) && (cmd.addr[31:16] != uncached_hi_b);
        n_beats     = 0;
        beat.addr   = cmd.addr;
        beat.wdata  = cmd.wdata;
        beat.size   = cmd.size;
        beat.write  = cmd.write;
        beat.single = !cacheable && !cmd.write;
        if (cmd.write) begin
            exp_q.push_back(beat);
            n_beats = 1;
            image[cmd.addr[13:2]] = merge_store(image[cmd.addr[13:2]], cmd);
        end else if (!cacheable) begin
            exp_q.push_back(beat);
            n_beats = 1;
        end else if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
            // Refill walks the line from its base
            for (int i = 0; i < refill_beats; i++) begin
                beat.addr = {cmd.addr[31:4], 2'(i), 2'b00};
                exp_q.push_back(beat);
            end
            n_beats        = refill_beats;
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
        end
        started     = 1'b1;
        start_count = beat_count;
        @(posedge clk);
        core_req <= 1'b1;
        core_cmd <= cmd;
        @(negedge clk);
        while (core_wait) begin
            @(negedge clk);
        end
        if (!cmd.write) begin
            check_value("core_rdata", image_word(cmd.addr), core_rdata);
        end
        check_value("memory beats", n_beats, beat_count - start_count);
        exp_q.delete();
        @(posedge clk);
        core_req <= 1'b0;
    endtask

    task automatic load(input addr_t addr);
        core_req_t cmd;
        cmd.addr  = addr;
        cmd.wdata = '0;
        cmd.write = 1'b0;
        cmd.size  = size_word;
        run_access(cmd);
    endtask

    task automatic store(input addr_t addr, input word_t data, input acc_size_e size);
        core_req_t cmd;
        cmd.addr  = addr;
        cmd.wdata = data;
        cmd.write = 1'b1;
        cmd.size  = size;
        run_access(cmd);
    endtask

    // ==============================
    // Monitors
    // ==============================
    // Quiet outputs between reset and the first access
    always @(negedge clk) begin
        if (!rst && !started) begin
            check_value("core_wait", 1'b0, core_wait);
            check_value("mem_rreq", 1'b0, mem_rreq);
            check_value("mem_wreq", 1'b0, mem_wreq);
            check_value("core_rdata", '0, core_rdata);
        end
    end

    // A beat completes at the next edge when mem_wait is low
    always @(negedge clk) begin : beat_check
        mem_req_t want;
        if (!rst && (mem_rreq || mem_wreq) && !mem_wait) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected memory request at %0t to address %h", $time, mem_cmd.addr);
                errors++;
            end else begin
                want = exp_q.pop_front();
                check_value("mem_cmd.addr", want.addr, mem_cmd.addr);
                check_value("mem_rreq", !want.write, mem_rreq);
                check_value("mem_wreq", want.write, mem_wreq);
                check_value("mem_cmd.write", want.write, mem_cmd.write);
                check_value("mem_cmd.single", want.single, mem_cmd.single);
                if (want.write) begin
                    check_value("mem_cmd.wdata", want.wdata, mem_cmd.wdata);
                    check_value("mem_cmd.size", want.size, mem_cmd.size);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int mark;
        core_req = 1'b0;
        core_cmd = '0;
        started  = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            image[i] = fill_word(32'(i) << 2);
        end
        for (int i = 0; i < 64; i++) begin
            ref_valid[i] = 1'b0;
        end

        mark = errors;
        wait (rst === 1'b0);
        repeat (3) @(negedge clk);
        report_test("reset outputs", mark);

        mark = errors;
        load(32'h0000_0238);
        load(32'h0000_0230);
        load(32'h0000_023c);
        report_test("load miss then hit", mark);

        mark = errors;
        store(32'h0000_0231, 32'h0000_00a5, size_byte);
        store(32'h0000_0236, 32'h0000_beef, size_half);
        store(32'h0000_0238, 32'h1234_5678, size_word);
        load(32'h0000_0230);
        load(32'h0000_0234);
        load(32'h0000_0238);
        report_test("store hits merge", mark);

        mark = errors;
        store(32'h0000_0840, 32'hcafe_f00d, size_word);
        store(32'h0000_0845, 32'h0000_0033, size_byte);
        load(32'h0000_0844);
        load(32'h0000_0840);
        report_test("store miss no allocate", mark);

        mark = errors;
        load(32'h1000_0010);
        load(32'h1000_0010);
        load(32'h4000_0ab8);
        load(32'h4000_0ab8);
        report_test("uncached windows", mark);

        // Same index, different tags
        mark = errors;
        load(32'h0000_0100);
        load(32'h0000_0504);
        load(32'h0000_0100);
        load(32'h0000_0504);
        load(32'h0000_0108);
        load(32'h0000_050c);
        report_test("index conflict", mark);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/dcache_pkg.sv
hw/sram_array.sv
hw/store_align.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
sim/tb_clock_gen.sv
sim/mem_model.sv
sim/tb_dcache.sv
